// File: Makefile
TOP = tb_cpu

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: tb.f
+incdir+verilog
+incdir+test
verilog/rv_pkg.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_pipelined.sv
test/tb_cpu.sv

// File: test/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Base encoders, register and immediate arguments are plain integers
function automatic rv_pkg::word_t i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                         input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
endfunction

function automatic rv_pkg::word_t r_type(input logic [2:0] funct3, input logic sub,
                                         input int rd, input int rs1, input int rs2);
    return {1'b0, sub, 5'b00000, rs2[4:0], rs1[4:0], funct3, rd[4:0], `OPCODE_R_TYPE};
endfunction

function automatic rv_pkg::word_t sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OPCODE_STORE};
endfunction

function automatic rv_pkg::word_t lw(input int rd, input int rs1, input int imm);
    return i_type(`OPCODE_LOAD, 3'b010, rd, rs1, imm);
endfunction

function automatic rv_pkg::word_t addi(input int rd, input int rs1, input int imm);
    return i_type(`OPCODE_ARITH, 3'b000, rd, rs1, imm);
endfunction

function automatic rv_pkg::word_t andi(input int rd, input int rs1, input int imm);
    return i_type(`OPCODE_ARITH, 3'b111, rd, rs1, imm);
endfunction

function automatic rv_pkg::word_t ori(input int rd, input int rs1, input int imm);
    return i_type(`OPCODE_ARITH, 3'b110, rd, rs1, imm);
endfunction

function automatic rv_pkg::word_t slti(input int rd, input int rs1, input int imm);
    return i_type(`OPCODE_ARITH, 3'b010, rd, rs1, imm);
endfunction

function automatic rv_pkg::word_t add_reg(input int rd, input int rs1, input int rs2);
    return r_type(3'b000, 1'b0, rd, rs1, rs2);
endfunction

function automatic rv_pkg::word_t sub_reg(input int rd, input int rs1, input int rs2);
    return r_type(3'b000, 1'b1, rd, rs1, rs2);
endfunction

function automatic rv_pkg::word_t and_reg(input int rd, input int rs1, input int rs2);
    return r_type(3'b111, 1'b0, rd, rs1, rs2);
endfunction

function automatic rv_pkg::word_t or_reg(input int rd, input int rs1, input int rs2);
    return r_type(3'b110, 1'b0, rd, rs1, rs2);
endfunction

function automatic rv_pkg::word_t slt_reg(input int rd, input int rs1, input int rs2);
    return r_type(3'b010, 1'b0, rd, rs1, rs2);
endfunction

`endif

// File: test/tb_cpu.sv
`include "rv_config.svh"

module tb_cpu;

    localparam int            DRIVE_DELAY   = 10;
    localparam int            IMEM_WORDS    = 64;
    localparam int            DMEM_WORDS    = 256;
    localparam int            STORE_TIMEOUT = 500;
    localparam rv_pkg::word_t NOP           = 32'h0000_0013;    // ADDI x0, x0, 0

    logic            clk;
    logic            reset;
    rv_pkg::word_t   instr_addr;
    rv_pkg::word_t   instr_data;
    rv_pkg::wb_req_t wb_req;
    rv_pkg::wb_rsp_t wb_rsp;

    rv_pkg::word_t instr_mem [IMEM_WORDS];
    rv_pkg::word_t data_mem [DMEM_WORDS];
    int            prog_len;
    int            ack_delay_max;    // Zero gives an ack in the first cycle

    rv_pkg::word_t store_adr_q[$];   // Stores seen by the slave in order
    rv_pkg::word_t store_dat_q[$];
    rv_pkg::word_t exp_adr_q[$];
    rv_pkg::word_t exp_dat_q[$];

    `include "tb_programs.svh"

    cpu_pipelined cpu_pipelined_i (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Combinational fetch port with NOPs past the program array
    always_comb begin
        if (instr_addr < rv_pkg::word_t'(IMEM_WORDS * 4)) begin
            instr_data = instr_mem[instr_addr[7:2]];
        end else begin
            instr_data = NOP;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("TESTS FAILED");
        $fatal(1, why);
    endtask

    task automatic compare_word(input rv_pkg::word_t actual, input rv_pkg::word_t expected,
                                input string what);
        if (actual !== expected) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_with_failure("a checked value did not match");
        end
    endtask

    task automatic compare_bus_idle(input rv_pkg::wb_req_t req, input string when);
        if (req.cyc !== 1'b0 || req.stb !== 1'b0) begin
            $display("Error at time %0t: bus active %s, cyc %b stb %b", $time, when,
                     req.cyc, req.stb);
            stop_with_failure("the bus was not idle around reset");
        end
    endtask

    task automatic compare_request(input rv_pkg::wb_req_t actual,
                                   input rv_pkg::wb_req_t expected);
        if (actual.we !== expected.we || actual.adr !== expected.adr ||
            actual.dat !== expected.dat) begin
            $display("Error at time %0t: request changed before ack, we %b adr %h dat %h, %s",
                     $time, actual.we, actual.adr, actual.dat, "first seen differently");
            stop_with_failure("a bus request changed while waiting for ack");
        end
    endtask

    function automatic rv_pkg::word_t less_signed(input rv_pkg::word_t a, input rv_pkg::word_t b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    function automatic int pick_ack_delay();
        if (ack_delay_max == 0) begin
            return 0;
        end
        return int'($urandom_range(ack_delay_max, 0));
    endfunction

    // Raising ack here ends the transfer at the next edge
    task automatic complete_access();
        if (wb_req.we) begin
            data_mem[wb_req.adr[9:2]] = wb_req.dat;
            store_adr_q.push_back(wb_req.adr);
            store_dat_q.push_back(wb_req.dat);
        end else begin
            wb_rsp.dat = data_mem[wb_req.adr[9:2]];
        end
        wb_rsp.ack = 1'b1;
    endtask

    // Wishbone slave model
    initial begin : wishbone_slave
        rv_pkg::wb_req_t held;
        int              wait_left;
        logic            in_cycle;
        void'($urandom(32'h6594_0bad));
        wb_rsp    = '0;
        held      = '0;
        wait_left = 0;
        in_cycle  = 1'b0;
        forever begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (wb_rsp.ack) begin
                wb_rsp   = '0;    // Transfer ended at this edge
                in_cycle = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!in_cycle) begin
                    in_cycle  = 1'b1;
                    held      = wb_req;
                    wait_left = pick_ack_delay();
                end else begin
                    compare_request(wb_req, held);
                end
                if (wait_left == 0) begin
                    complete_access();
                end else begin
                    wait_left--;
                end
            end else begin
                in_cycle = 1'b0;    // Cycle dropped by reset
            end
        end
    end

    task automatic clear_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            instr_mem[i[5:0]] = NOP;
        end
        prog_len = 0;
        exp_adr_q.delete();
        exp_dat_q.delete();
    endtask

    task automatic emit(input rv_pkg::word_t instr);
        instr_mem[prog_len[5:0]] = instr;
        prog_len++;
    endtask

    task automatic expect_store(input int adr, input rv_pkg::word_t dat);
        exp_adr_q.push_back(rv_pkg::word_t'(adr));
        exp_dat_q.push_back(dat);
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        repeat (8) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            compare_bus_idle(wb_req, "during reset");
            compare_word(instr_addr, `RESET_PC, "instr_addr during reset");
        end
        reset = 1'b0;
        @(negedge clk);    // Before the first edge with reset low
        compare_bus_idle(wb_req, "after reset");
        compare_word(instr_addr, `RESET_PC, "instr_addr after reset");
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_for_stores(input int count);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > STORE_TIMEOUT) begin
                stop_with_failure("timed out waiting for the program's stores");
            end
        end while (store_adr_q.size() < count);
        #(DRIVE_DELAY);
    endtask

    task automatic run_program(input string name);
        store_adr_q.delete();
        store_dat_q.delete();
        reset_dut();
        wait_for_stores(exp_adr_q.size());
        foreach (exp_adr_q[i]) begin
            compare_word(store_adr_q[i], exp_adr_q[i], $sformatf("%s store %0d address", name, i));
            compare_word(store_dat_q[i], exp_dat_q[i], $sformatf("%s store %0d data", name, i));
        end
    endtask

    task automatic reset_test();
        clear_program();
        reset_dut();
    endtask

    task automatic imm_chain_test();
        rv_pkg::word_t r1, r2, r3, r4, r5, r6, r8;
        clear_program();
        emit(addi(1, 0, 100));
        emit(addi(2, 1, -37));        // From EX/MEM
        emit(andi(3, 2, 'h0f0));
        emit(ori(4, 3, 'h705));
        emit(slti(5, 3, 49));         // From MEM/WB
        emit(slti(6, 2, -1));
        emit(andi(8, 1, -4));
        emit(addi(7, 0, 64));
        emit(sw(4, 7, 4));
        emit(sw(5, 7, -8));
        emit(sw(6, 0, 12));
        emit(sw(8, 7, 0));
        r1 = 32'd100;
        r2 = r1 + rv_pkg::word_t'(-37);
        r3 = r2 & 32'h0000_00f0;
        r4 = r3 | 32'h0000_0705;
        r5 = less_signed(r3, 32'd49);
        r6 = less_signed(r2, rv_pkg::word_t'(-1));
        r8 = r1 & rv_pkg::word_t'(-4);
        expect_store(68, r4);
        expect_store(56, r5);
        expect_store(12, r6);
        expect_store(64, r8);
        run_program("immediate chain");
    endtask

    task automatic reg_form_test();
        rv_pkg::word_t a, b;
        rv_pkg::word_t vals[$];
        clear_program();
        a = rv_pkg::word_t'(-20);
        b = 32'd7;
        emit(addi(1, 0, -20));
        emit(addi(2, 0, 7));
        emit(add_reg(3, 1, 2));
        emit(sub_reg(4, 2, 1));
        emit(and_reg(5, 1, 2));
        emit(or_reg(6, 1, 2));
        emit(slt_reg(7, 1, 2));       // Negative against positive
        emit(slt_reg(8, 2, 1));
        emit(sub_reg(9, 3, 4));
        vals.push_back(a + b);
        vals.push_back(b - a);
        vals.push_back(a & b);
        vals.push_back(a | b);
        vals.push_back(less_signed(a, b));
        vals.push_back(less_signed(b, a));
        vals.push_back(vals[0] - vals[1]);
        foreach (vals[k]) begin
            emit(sw(k + 3, 0, 4 * k));
            expect_store(4 * k, vals[k]);
        end
        run_program("register forms");
    endtask

    task automatic load_use_test();
        clear_program();
        data_mem[32] = 32'h0123_4567;
        data_mem[33] = 32'h89ab_cdef;
        emit(addi(1, 0, 128));
        emit(addi(2, 0, 300));
        emit(lw(3, 1, 0));
        emit(add_reg(4, 3, 2));       // Needs the loaded word at once
        emit(sw(4, 1, 8));
        emit(lw(5, 1, 4));
        emit(sw(5, 1, 12));           // Store data straight from a load
        expect_store(136, 32'h0123_4567 + 32'd300);
        expect_store(140, 32'h89ab_cdef);
        run_program("load-use");
    endtask

    task automatic zero_reg_test();
        clear_program();
        emit(addi(0, 0, 55));
        emit(addi(1, 0, 9));
        emit(add_reg(0, 1, 1));
        emit(sw(0, 0, 20));           // x0 in EX/MEM as base and data
        emit(sw(1, 0, 24));
        expect_store(20, 32'd0);
        expect_store(24, 32'd9);
        run_program("register zero");
    endtask

    task automatic back_pressure_test();
        ack_delay_max = 4;
        imm_chain_test();
        reg_form_test();
        load_use_test();
        zero_reg_test();
        ack_delay_max = 0;
    endtask

    initial begin
        reset         = 1'b1;
        ack_delay_max = 0;
        prog_len      = 0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            data_mem[i[7:0]] = rv_pkg::word_t'(i * 4) ^ 32'h5a5a_0000;    // Address-based fill
        end
        clear_program();
        reset_test();
        imm_chain_test();
        reg_form_test();
        load_use_test();
        zero_reg_test();
        back_pressure_test();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog/cpu_pipelined.sv
`include "rv_config.svh"

module cpu_pipelined (
    input  logic            clk,
    input  logic            reset,
    output rv_pkg::word_t   instr_addr,
    input  rv_pkg::word_t   instr_data,
    output rv_pkg::wb_req_t wb_req,
    input  rv_pkg::wb_rsp_t wb_rsp
);
    rv_pkg::word_t     pc;
    rv_pkg::word_t     if_id_instr;
    logic              if_id_valid;

    rv_pkg::ctrl_t     dec_ctrl;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::wb_t       wb_result;
    logic              stall;
    logic              busy;
    logic              hold;

    assign hold       = stall || busy;    // Front end frozen
    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (!hold) begin
            pc <= pc + rv_pkg::word_t'(4);
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (reset) begin
            if_id_valid <= 1'b0;
        end else if (!hold) begin
            if_id_instr <= instr_data;
            if_id_valid <= 1'b1;
        end
    end

    decoder u_decoder (
        .instr (if_id_instr),
        .valid (if_id_valid),
        .ctrl  (dec_ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    register_file u_register_file (
        .clk      (clk),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_result)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .reset    (reset),
        .busy     (busy),
        .id_valid (if_id_valid),
        .ctrl     (dec_ctrl),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_result),
        .stall    (stall),
        .ex_mem   (ex_mem)
    );

    memory_stage u_memory_stage (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .busy   (busy),
        .wb     (wb_result)
    );

endmodule

// File: verilog/decoder.sv
`include "rv_config.svh"

module decoder (
    input  rv_pkg::word_t     instr,
    input  logic              valid,
    output rv_pkg::ctrl_t     ctrl,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm
);
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_r_type;
    logic            arith_known;   // Supported funct3/funct7 combination
    rv_pkg::alu_op_t arith_op;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rd        = instr[11:7];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign is_r_type = (opcode == `OPCODE_R_TYPE);

    // ALU operation, shared by register and immediate forms
    always_comb begin
        arith_known = 1'b1;
        case (funct3)
            3'b000:  arith_op = (is_r_type && instr[30]) ? `ALU_SUB : `ALU_ADD;
            3'b111:  arith_op = `ALU_AND;
            3'b110:  arith_op = `ALU_OR;
            3'b010:  arith_op = `ALU_SLT;
            default: begin
                arith_op    = `ALU_ADD;
                arith_known = 1'b0;
            end
        endcase
        if (is_r_type && (instr[31] || instr[29:25] != 5'b0 || (instr[30] && funct3 != 3'b000))) begin
            arith_known = 1'b0;    // Other funct7 values
        end
    end

    always_comb begin
        case (opcode)
            `OPCODE_LOAD, `OPCODE_ARITH: imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            `OPCODE_STORE:               imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            default:                     imm = '0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        if (valid) begin
            case (opcode)
                `OPCODE_LOAD: begin
                    ctrl.alu_src    = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_read   = 1'b1;
                    ctrl.alu_op     = `ALU_ADD;    // Base plus offset
                end
                `OPCODE_STORE: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_op    = `ALU_ADD;
                end
                `OPCODE_ARITH: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = arith_known;
                    ctrl.alu_op    = arith_op;
                end
                `OPCODE_R_TYPE: begin
                    ctrl.reg_write = arith_known;
                    ctrl.alu_op    = arith_op;
                end
                default: begin
                    // Unknown opcode acts as a no-op
                end
            endcase
        end
    end

endmodule

// File: verilog/execute_stage.sv
`include "rv_config.svh"

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              busy,
    input  logic              id_valid,
    input  rv_pkg::ctrl_t     ctrl,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     imm,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::wb_t       wb,
    output logic              stall,
    output rv_pkg::ex_mem_t   ex_mem
);
    // ID/EX register
    logic              id_ex_valid;
    rv_pkg::ctrl_t     id_ex_ctrl;
    rv_pkg::reg_addr_t id_ex_rs1;
    rv_pkg::reg_addr_t id_ex_rs2;
    rv_pkg::reg_addr_t id_ex_rd;
    rv_pkg::word_t     id_ex_imm;
    rv_pkg::word_t     id_ex_rs1_data;
    rv_pkg::word_t     id_ex_rs2_data;

    rv_pkg::word_t     op_a;
    rv_pkg::word_t     op_b;
    rv_pkg::word_t     store_data;
    rv_pkg::word_t     alu_result;

    // Load in ID/EX feeding the instruction in decode
    assign stall = id_valid && id_ex_valid && id_ex_ctrl.mem_read && id_ex_rd != '0 &&
                   (id_ex_rd == rs1 || id_ex_rd == rs2);

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex_valid <= 1'b0;
            id_ex_ctrl  <= '0;
        end else if (!busy) begin
            id_ex_valid    <= id_valid && !stall;
            id_ex_ctrl     <= stall ? '0 : ctrl;    // Bubble
            id_ex_rs1      <= rs1;
            id_ex_rs2      <= rs2;
            id_ex_rd       <= rd;
            id_ex_imm      <= imm;
            id_ex_rs1_data <= rs1_data;
            id_ex_rs2_data <= rs2_data;
        end
    end

    // Newest producer wins
    function automatic rv_pkg::word_t forward(input rv_pkg::reg_addr_t rs,
                                              input rv_pkg::word_t rf_data);
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == rs) begin
            return ex_mem.alu_result;
        end else if (wb.valid && wb.rd != '0 && wb.rd == rs) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    always_comb begin
        op_a       = forward(id_ex_rs1, id_ex_rs1_data);
        store_data = forward(id_ex_rs2, id_ex_rs2_data);
        op_b       = id_ex_ctrl.alu_src ? id_ex_imm : store_data;
        case (id_ex_ctrl.alu_op)
            `ALU_ADD: alu_result = op_a + op_b;
            `ALU_SUB: alu_result = op_a - op_b;
            `ALU_AND: alu_result = op_a & op_b;
            `ALU_OR:  alu_result = op_a | op_b;
            `ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:  alu_result = '0;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else if (!busy) begin
            ex_mem.valid      <= id_ex_valid;
            ex_mem.reg_write  <= id_ex_ctrl.reg_write;
            ex_mem.mem_read   <= id_ex_ctrl.mem_read;
            ex_mem.mem_write  <= id_ex_ctrl.mem_write;
            ex_mem.mem_to_reg <= id_ex_ctrl.mem_to_reg;
            ex_mem.rd         <= id_ex_rd;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= store_data;
        end
    end

endmodule

// File: verilog/memory_stage.sv
module memory_stage (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::ex_mem_t ex_mem,
    output rv_pkg::wb_req_t wb_req,
    input  rv_pkg::wb_rsp_t wb_rsp,
    output logic            busy,
    output rv_pkg::wb_t     wb
);
    rv_pkg::bus_state_t state;
    logic               mem_op;
    logic               done;    // Ack for the open cycle

    assign mem_op = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // Request fields come straight from EX/MEM, which holds until ack
    always_comb begin
        wb_req.cyc = mem_op && (state == rv_pkg::BUS_IDLE);
        wb_req.stb = wb_req.cyc;
        wb_req.we  = ex_mem.mem_write;
        wb_req.adr = ex_mem.alu_result;
        wb_req.dat = ex_mem.store_data;
    end

    assign done = wb_req.cyc && wb_rsp.ack;
    assign busy = mem_op && !done;

    // BUS_WAIT keeps cyc low for one cycle after each ack
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_pkg::BUS_IDLE;
        end else begin
            case (state)
                rv_pkg::BUS_IDLE: begin
                    if (done) begin
                        state <= rv_pkg::BUS_WAIT;
                    end
                end
                rv_pkg::BUS_WAIT: state <= rv_pkg::BUS_IDLE;
                default:          state <= rv_pkg::BUS_IDLE;
            endcase
        end
    end

    // MEM/WB register, load data sampled on the ack edge
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else if (!busy) begin
            wb.valid <= ex_mem.valid && ex_mem.reg_write;
            wb.rd    <= ex_mem.rd;
            wb.data  <= ex_mem.mem_to_reg ? wb_rsp.dat : ex_mem.alu_result;
        end
    end

endmodule

// File: verilog/register_file.sv
`include "rv_config.svh"

module register_file (
    input  logic              clk,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  rv_pkg::wb_t       wb
);
    rv_pkg::word_t regs [`REG_COUNT];

    // Write-through gives the value being written this cycle
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb.valid && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != '0) begin    // x0 stays zero
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// File: verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

`define XLEN      32
`define REG_COUNT 32
`define RESET_PC  32'h0000_0000    // First fetch address

// Opcodes of the supported instruction classes
`define OPCODE_LOAD   7'b0000011
`define OPCODE_STORE  7'b0100011
`define OPCODE_ARITH  7'b0010011
`define OPCODE_R_TYPE 7'b0110011

`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_SLT 3'd4

`endif

// File: verilog/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]               word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0]  reg_addr_t;
    typedef logic [2:0]                     alu_op_t;

    typedef struct packed {
        logic    alu_src;       // Immediate as operand b
        logic    mem_to_reg;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        reg_addr_t rd;
        word_t     alu_result;  // Result or memory address
        word_t     store_data;
    } ex_mem_t;

    // Valid here means a register write
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_t;

endpackage
